//--- source/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // table geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    // field widths
    localparam int VPPN_W    = 19;
    localparam int VPPN_HI_W = 9;
    localparam int VPPN_LO_W = VPPN_W - VPPN_HI_W;
    localparam int ASID_W    = 10;
    localparam int PPN_W     = 20;
    localparam int PS_W      = 6;

    // page size codes, log2 of the page size in bytes
    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd22;

    // invtlb opcodes, 7 and above are no-ops
    typedef enum logic [4:0] {
        inv_all               = 5'd0,
        inv_all_alt           = 5'd1,
        inv_global            = 5'd2,
        inv_private           = 5'd3,
        inv_private_asid      = 5'd4,
        inv_private_asid_va   = 5'd5,
        inv_asid_or_global_va = 5'd6
    } invtlb_op_e;

    // one half of a double page
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       plv;
        logic [1:0]       mat;
        logic             d;
        logic             v;
    } tlb_page_t;

    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [PS_W-1:0]   ps;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              va_bit12;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [PPN_W-1:0]     ppn;
        logic [PS_W-1:0]      ps;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_search_rsp_t;

    typedef struct packed {
        logic              valid;
        invtlb_op_e        op;
        logic [ASID_W-1:0] asid;
        logic [VPPN_W-1:0] vppn;
    } tlb_invtlb_req_t;

endpackage

`default_nettype wire

//--- source/tlb_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  logic [TLB_IDX_W-1:0] w_index,
    input  tlb_entry_t           w_entry,
    input  logic                 inv_valid,
    input  logic [TLB_NUM-1:0]   inv_mask,
    input  logic [TLB_IDX_W-1:0] r_index,
    output tlb_entry_t           r_entry,
    output tlb_entry_t           entries [TLB_NUM]
);

    // exist bits, the only state under reset
    logic [TLB_NUM-1:0] e_q;

    // payload storage
    logic [TLB_NUM-1:0] ps_4m_q;
    logic [TLB_NUM-1:0] g_q;
    logic [VPPN_W-1:0]  vppn_q  [TLB_NUM];
    logic [ASID_W-1:0]  asid_q  [TLB_NUM];
    tlb_page_t          page0_q [TLB_NUM];
    tlb_page_t          page1_q [TLB_NUM];

    // anything other than 22 is kept as 4KB
    logic w_is_4m;

    assign w_is_4m = (w_entry.ps == PS_4M);

    // a write wins over a same-cycle invalidate
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            e_q <= '0;
        end
        else if (we)
        begin
            e_q[w_index] <= w_entry.e;
        end
        else if (inv_valid)
        begin
            e_q <= e_q & ~inv_mask;
        end
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            ps_4m_q[w_index] <= w_is_4m;
            g_q[w_index]     <= w_entry.g;
            vppn_q[w_index]  <= w_entry.vppn;
            asid_q[w_index]  <= w_entry.asid;
            page0_q[w_index] <= w_entry.page0;
            page1_q[w_index] <= w_entry.page1;
        end
    end

    // full entry view, ps rebuilt from the size flag
    always_comb
    begin
        for (int i = 0; i < TLB_NUM; i++)
        begin
            entries[i].e     = e_q[i];
            entries[i].vppn  = vppn_q[i];
            entries[i].ps    = ps_4m_q[i] ? PS_4M : PS_4K;
            entries[i].asid  = asid_q[i];
            entries[i].g     = g_q[i];
            entries[i].page0 = page0_q[i];
            entries[i].page1 = page1_q[i];
        end
    end

    assign r_entry = entries[r_index];

    // write strobe and its index must be clean once out of reset
    a_write_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(we) && (!we || !$isunknown(w_index))
    );

endmodule

`default_nettype wire

//--- source/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup
    import tlb_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  tlb_search_req_t req,
    input  tlb_entry_t      entries [TLB_NUM],
    output tlb_search_rsp_t rsp
);

    logic [TLB_NUM-1:0]   hit_vec;
    logic [TLB_IDX_W-1:0] hit_idx;
    tlb_entry_t           hit;
    logic                 is_4m;
    logic                 odd;
    tlb_page_t            page;

    // per-entry compare
    always_comb
    begin
        for (int i = 0; i < TLB_NUM; i++)
        begin
            hit_vec[i] = entries[i].e
                && (entries[i].vppn[VPPN_W-1 -: VPPN_HI_W] == req.vppn[VPPN_W-1 -: VPPN_HI_W])
                && (entries[i].ps == PS_4M
                    || entries[i].vppn[VPPN_LO_W-1:0] == req.vppn[VPPN_LO_W-1:0])
                && (entries[i].g || entries[i].asid == req.asid);
        end
    end

    // lowest index wins, scan from the top down
    always_comb
    begin
        hit_idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--)
        begin
            if (hit_vec[i])
            begin
                hit_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign hit   = entries[hit_idx];
    assign is_4m = (hit.ps == PS_4M);

    // 4MB: odd half picked by va bit 22, which is vppn bit 9
    assign odd  = is_4m ? req.vppn[VPPN_LO_W-1] : req.va_bit12;
    assign page = odd ? hit.page1 : hit.page0;

    always_comb
    begin
        rsp.found = |hit_vec;
        rsp.index = hit_idx;
        rsp.ppn   = page.ppn;
        rsp.ps    = hit.ps;
        rsp.plv   = page.plv;
        rsp.mat   = page.mat;
        rsp.d     = page.d;
        rsp.v     = page.v;
    end

    // reported entry really covers the request, as seen through the response
    a_hit_consistent: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.found |-> entries[rsp.index].e
            && (entries[rsp.index].vppn[VPPN_W-1 -: VPPN_HI_W]
                == req.vppn[VPPN_W-1 -: VPPN_HI_W])
            && (rsp.ps == PS_4M
                || entries[rsp.index].vppn[VPPN_LO_W-1:0] == req.vppn[VPPN_LO_W-1:0])
            && (entries[rsp.index].g || entries[rsp.index].asid == req.asid)
    );

endmodule

`default_nettype wire

//--- source/tlb_invalidate_match.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_invalidate_match
    import tlb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  tlb_invtlb_req_t    inv_req,
    input  tlb_entry_t         entries [TLB_NUM],
    output logic               inv_valid,
    output logic [TLB_NUM-1:0] inv_mask
);

    logic [TLB_NUM-1:0] is_global;
    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] va_eq;
    logic               op_known;

    // per-entry conditions where the va compare ignores e and asid
    always_comb
    begin
        for (int i = 0; i < TLB_NUM; i++)
        begin
            is_global[i] = entries[i].g;
            asid_eq[i]   = (entries[i].asid == inv_req.asid);
            va_eq[i]     = (entries[i].vppn[VPPN_W-1 -: VPPN_HI_W]
                            == inv_req.vppn[VPPN_W-1 -: VPPN_HI_W])
                && (entries[i].ps == PS_4M
                    || entries[i].vppn[VPPN_LO_W-1:0] == inv_req.vppn[VPPN_LO_W-1:0]);
        end
    end

    always_comb
    begin
        op_known = 1'b1;
        case (inv_req.op)
            inv_all, inv_all_alt:  inv_mask = '1;
            inv_global:            inv_mask = is_global;
            inv_private:           inv_mask = ~is_global;
            inv_private_asid:      inv_mask = ~is_global & asid_eq;
            inv_private_asid_va:   inv_mask = ~is_global & asid_eq & va_eq;
            inv_asid_or_global_va: inv_mask = (is_global | asid_eq) & va_eq;
            default:
            begin
                op_known = 1'b0;
                inv_mask = '0;
            end
        endcase
    end

    assign inv_valid = inv_req.valid && op_known;

    // a valid command carries a known opcode
    a_valid_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        inv_req.valid |-> !$isunknown(inv_req.op)
    );

endmodule

`default_nettype wire

//--- source/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_top
    import tlb_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // fetch and load/store search
    input  tlb_search_req_t      s0_req,
    input  tlb_search_req_t      s1_req,
    output tlb_search_rsp_t      s0_rsp,
    output tlb_search_rsp_t      s1_rsp,

    input  logic                 we,
    input  logic [TLB_IDX_W-1:0] w_index,
    input  tlb_entry_t           w_entry,

    input  logic [TLB_IDX_W-1:0] r_index,
    output tlb_entry_t           r_entry,

    input  tlb_invtlb_req_t      inv_req
);

    tlb_entry_t         entries [TLB_NUM];
    logic               inv_valid;
    logic [TLB_NUM-1:0] inv_mask;

    tlb_entry_array entry_array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .inv_valid (inv_valid),
        .inv_mask  (inv_mask),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .entries   (entries)
    );

    tlb_lookup fetch_lookup (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (s0_req),
        .entries (entries),
        .rsp     (s0_rsp)
    );

    tlb_lookup data_lookup (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (s1_req),
        .entries (entries),
        .rsp     (s1_rsp)
    );

    tlb_invalidate_match inv_match_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .inv_req   (inv_req),
        .entries   (entries),
        .inv_valid (inv_valid),
        .inv_mask  (inv_mask)
    );

endmodule

`default_nettype wire

//--- tb/tlb_ref_model.svh
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// shadow copy of the table, ps held in its stored form
tlb_entry_t shadow [TLB_NUM];

// upper 9 bits always compared, a 4MB entry ignores the low 10
function automatic logic va_covers(input tlb_entry_t ent, input logic [VPPN_W-1:0] vppn);
    if (ent.vppn[VPPN_W-1:VPPN_LO_W] != vppn[VPPN_W-1:VPPN_LO_W])
        return 1'b0;
    return ent.ps == PS_4M || ent.vppn[VPPN_LO_W-1:0] == vppn[VPPN_LO_W-1:0];
endfunction

function automatic logic search_hits(input tlb_entry_t ent, input tlb_search_req_t req);
    return ent.e && va_covers(ent, req.vppn) && (ent.g || ent.asid == req.asid);
endfunction

function automatic tlb_search_rsp_t ref_search(input tlb_search_req_t req);
    tlb_search_rsp_t rsp;
    tlb_entry_t      ent;
    tlb_page_t       pg;
    logic            odd;
    rsp.found = 1'b0;
    rsp.index = '0;
    for (int i = 0; i < TLB_NUM; i++)
    begin
        if (!rsp.found && search_hits(shadow[i], req))
        begin
            rsp.found = 1'b1;
            rsp.index = TLB_IDX_W'(i);
        end
    end
    ent = shadow[rsp.index];
    // va bit 22 sits at vppn bit 9
    odd = (ent.ps == PS_4M) ? req.vppn[9] : req.va_bit12;
    pg  = odd ? ent.page1 : ent.page0;
    rsp.ppn = pg.ppn;
    rsp.ps  = ent.ps;
    rsp.plv = pg.plv;
    rsp.mat = pg.mat;
    rsp.d   = pg.d;
    rsp.v   = pg.v;
    return rsp;
endfunction

function automatic logic [TLB_NUM-1:0] ref_inv_mask(input tlb_invtlb_req_t ir);
    logic [TLB_NUM-1:0] mask;
    logic               asid_m;
    logic               va_m;
    for (int i = 0; i < TLB_NUM; i++)
    begin
        asid_m = (shadow[i].asid == ir.asid);
        va_m   = va_covers(shadow[i], ir.vppn);
        case (5'(ir.op))
            5'd0, 5'd1: mask[i] = 1'b1;
            5'd2:       mask[i] = shadow[i].g;
            5'd3:       mask[i] = !shadow[i].g;
            5'd4:       mask[i] = !shadow[i].g && asid_m;
            5'd5:       mask[i] = !shadow[i].g && asid_m && va_m;
            5'd6:       mask[i] = (shadow[i].g || asid_m) && va_m;
            default:    mask[i] = 1'b0;
        endcase
    end
    return mask;
endfunction

// any size other than 22 is kept as 4KB
function automatic tlb_entry_t stored_form(input tlb_entry_t ent);
    ent.ps = (ent.ps == PS_4M) ? PS_4M : PS_4K;
    return ent;
endfunction

function automatic void shadow_update(input logic do_write, input logic [TLB_IDX_W-1:0] idx,
                                      input tlb_entry_t ent, input tlb_invtlb_req_t ir);
    logic [TLB_NUM-1:0] mask;
    mask = ref_inv_mask(ir);
    // same-cycle invalidate is dropped when a write happens
    if (do_write)
        shadow[idx] = stored_form(ent);
    else if (ir.valid)
    begin
        for (int i = 0; i < TLB_NUM; i++)
        begin
            if (mask[i])
                shadow[i].e = 1'b0;
        end
    end
endfunction

`endif

//--- tb/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_tb
    import tlb_pkg::*;
();

    typedef enum {check_off, check_exist, check_full} check_mode_e;

    logic                 clk;
    logic                 rst_n;
    tlb_search_req_t      s0_req;
    tlb_search_req_t      s1_req;
    tlb_search_rsp_t      s0_rsp;
    tlb_search_rsp_t      s1_rsp;
    logic                 we;
    logic [TLB_IDX_W-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [TLB_IDX_W-1:0] r_index;
    tlb_entry_t           r_entry;
    tlb_invtlb_req_t      inv_req;

    check_mode_e mode;
    string       test_name;
    int          test_id;
    int          checks [5];
    int          errs [5];
    integer      seed;
    logic        timed_out;

    `include "tlb_ref_model.svh"

    tlb_top tlb_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .s0_req  (s0_req),
        .s1_req  (s1_req),
        .s0_rsp  (s0_rsp),
        .s1_rsp  (s1_rsp),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .inv_req (inv_req)
    );

    always #5 clk = ~clk;

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // small pools so hits, misses and duplicate matches all occur
    function automatic logic [VPPN_W-1:0] rand_vppn();
        logic [VPPN_HI_W-1:0] hi;
        logic [VPPN_LO_W-1:0] lo;
        hi = (pick(2) == 1) ? 9'h0a5 : 9'h1f0;
        case (pick(4))
            0:       lo = 10'h000;
            1:       lo = 10'h001;
            2:       lo = 10'h200;
            default: lo = 10'h3ff;
        endcase
        return {hi, lo};
    endfunction

    function automatic logic [ASID_W-1:0] rand_asid();
        return (pick(2) == 1) ? 10'h001 : 10'h2c4;
    endfunction

    function automatic tlb_search_req_t rand_req();
        tlb_search_req_t req;
        req.vppn     = rand_vppn();
        req.va_bit12 = (pick(2) == 1);
        req.asid     = rand_asid();
        return req;
    endfunction

    // mostly 4KB or 4MB, now and then an odd size code
    function automatic tlb_entry_t rand_entry();
        tlb_entry_t ent;
        ent.e     = (pick(4) != 0);
        ent.vppn  = rand_vppn();
        ent.ps    = (pick(2) == 1) ? PS_4M : ((pick(2) == 1) ? PS_4K : PS_W'(pick(64)));
        ent.asid  = rand_asid();
        ent.g     = (pick(4) == 0);
        ent.page0 = 25'($random(seed));
        ent.page1 = 25'($random(seed));
        return ent;
    endfunction

    task automatic run_cycle(input logic do_write, input logic [TLB_IDX_W-1:0] idx,
                             input tlb_entry_t ent, input tlb_invtlb_req_t ir,
                             input logic [TLB_IDX_W-1:0] rd_idx);
        @(posedge clk);
        we      <= do_write;
        w_index <= idx;
        w_entry <= ent;
        inv_req <= ir;
        r_index <= rd_idx;
        s0_req  <= rand_req();
        s1_req  <= rand_req();
    endtask

    task automatic fill_table(input logic all_exist);
        tlb_entry_t ent;
        for (int i = 0; i < TLB_NUM; i++)
        begin
            ent   = rand_entry();
            ent.e = ent.e | all_exist;
            run_cycle(1'b1, TLB_IDX_W'(i), ent, '0, TLB_IDX_W'(i));
        end
    endtask

    // walk the read port while both ports search at random
    task automatic read_all();
        for (int i = 0; i < TLB_NUM; i++)
        begin
            run_cycle(1'b0, '0, '0, '0, TLB_IDX_W'(i));
        end
    endtask

    task automatic start_test(input int id, input string name, input check_mode_e m);
        test_id   = id;
        test_name = name;
        mode      = m;
    endtask

    task automatic finish_test();
        @(posedge clk);
        we      <= 1'b0;
        inv_req <= '0;
        mode    <= check_off;
        @(negedge clk);
        $display("test %-14s %0d checks, %0d errors", test_name, checks[test_id], errs[test_id]);
    endtask

    task automatic report_err(input string what, input logic [127:0] exp, input logic [127:0] act);
        $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        errs[test_id]++;
    endtask

    task automatic wait_reset_clear();
        int n;
        n = 0;
        timed_out = 1'b1;
        while (timed_out && n < 16)
        begin
            @(negedge clk);
            if (rst_n && s0_rsp.found === 1'b0 && s1_rsp.found === 1'b0)
                timed_out = 1'b0;
            n++;
        end
        if (timed_out)
            $display("timeout: search ports still report hits 16 cycles after reset release");
    endtask

    // sample before the edge updates anything, then advance the shadow table
    always @(posedge clk)
    begin : compare_outputs
        tlb_search_rsp_t exp0;
        tlb_search_rsp_t exp1;
        tlb_entry_t      exp_r;
        if (!rst_n)
        begin
            for (int i = 0; i < TLB_NUM; i++)
                shadow[i].e = 1'b0;
        end
        else
        begin
            exp0  = ref_search(s0_req);
            exp1  = ref_search(s1_req);
            exp_r = shadow[r_index];
            if (mode == check_full)
            begin
                checks[test_id] += 3;
                if (s0_rsp !== exp0)
                    report_err("s0_rsp", exp0, s0_rsp);
                if (s1_rsp !== exp1)
                    report_err("s1_rsp", exp1, s1_rsp);
                if (r_entry !== exp_r)
                    report_err("r_entry", exp_r, r_entry);
            end
            else if (mode == check_exist)
            begin
                checks[test_id] += 3;
                if ({s0_rsp.found, s0_rsp.index} !== {exp0.found, exp0.index})
                    report_err("s0 found/index", {exp0.found, exp0.index},
                               {s0_rsp.found, s0_rsp.index});
                if ({s1_rsp.found, s1_rsp.index} !== {exp1.found, exp1.index})
                    report_err("s1 found/index", {exp1.found, exp1.index},
                               {s1_rsp.found, s1_rsp.index});
                if (r_entry.e !== exp_r.e)
                    report_err("r_entry.e", exp_r.e, r_entry.e);
            end
            shadow_update(we, w_index, w_entry, inv_req);
        end
    end

    initial
    begin
        tlb_invtlb_req_t ir;
        tlb_entry_t      ent;
        int              total_checks;
        int              total_errs;
        clk       = 1'b0;
        rst_n     = 1'b0;
        seed      = 16507;
        we        = 1'b0;
        w_index   = '0;
        w_entry   = '0;
        r_index   = '0;
        inv_req   = '0;
        s0_req    = '0;
        s1_req    = '0;
        mode      = check_off;
        test_id   = 0;
        test_name = "reset";
        checks    = '{default: 0};
        errs      = '{default: 0};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_clear();
        if (!timed_out)
        begin
            start_test(0, "reset", check_exist);
            read_all();
            read_all();
            finish_test();

            start_test(1, "write_read", check_exist);
            fill_table(1'b0);
            run_cycle(1'b0, '0, '0, '0, '0);
            mode <= check_full;
            read_all();
            finish_test();

            start_test(2, "search", check_full);
            for (int n = 0; n < 200; n++)
            begin
                run_cycle(pick(8) == 0, TLB_IDX_W'(pick(TLB_NUM)), rand_entry(), '0,
                          TLB_IDX_W'(pick(TLB_NUM)));
            end
            finish_test();

            // ops 7 to 9 must leave the table alone
            start_test(3, "invalidate", check_full);
            for (int op = 0; op < 10; op++)
            begin
                fill_table(1'b1);
                ir.valid = 1'b1;
                ir.op    = invtlb_op_e'(5'(op));
                ir.asid  = rand_asid();
                ir.vppn  = rand_vppn();
                run_cycle(1'b0, '0, '0, ir, '0);
                read_all();
            end
            finish_test();

            start_test(4, "write_and_inv", check_full);
            for (int n = 0; n < 4; n++)
            begin
                fill_table(1'b1);
                ent      = rand_entry();
                ent.e    = 1'b1;
                ir.valid = 1'b1;
                ir.op    = invtlb_op_e'(5'(pick(7)));
                ir.asid  = rand_asid();
                ir.vppn  = rand_vppn();
                run_cycle(1'b1, TLB_IDX_W'(pick(TLB_NUM)), ent, ir, '0);
                read_all();
            end
            finish_test();
        end
        total_checks = 0;
        total_errs   = timed_out ? 1 : 0;
        for (int i = 0; i < 5; i++)
        begin
            total_checks += checks[i];
            total_errs   += errs[i];
        end
        $display("summary: %0d checks, %0d errors", total_checks, total_errs);
        if (total_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+tb
source/tlb_pkg.sv
source/tlb_entry_array.sv
source/tlb_lookup.sv
source/tlb_invalidate_match.sv
source/tlb_top.sv
tb/tlb_tb.sv

//--- Bender.yml
package:
  name: tlb

sources:
  - source/tlb_pkg.sv
  - source/tlb_entry_array.sv
  - source/tlb_lookup.sv
  - source/tlb_invalidate_match.sv
  - source/tlb_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tlb_tb.sv
